// ==== dv/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen (
	output logic clk,
	output logic arst_n
);

	// 10 ns period
	initial clk = 1'b0;
	always #5 clk = ~clk;

	// Reset held for four rising edges
	initial begin
		arst_n = 1'b0;
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;
	end

endmodule

// ==== dv/fdbk_core_props.sv ====
`timescale 1ns/1ps

module fdbk_core_props (
	input logic                 clk,
	input logic                 arst_n,
	input logic                 sync,
	input logic                 dec_stb,
	input logic                 drv_stb,
	input fdbk_pkg::cmp_event_t cmp_event,
	input fdbk_pkg::sample_t    out_xy
);

	// Failed assertion count
	int fail_count = 0;

	// Frame of four I/Q pairs
	sync_period: assert property (@(posedge clk) disable iff (!arst_n)
		sync |=> (!sync) [*7] ##1 sync)
		else begin
			$error("sync did not repeat after exactly eight cycles");
			fail_count++;
		end

	// Strobes last one cycle
	dec_pulse: assert property (@(posedge clk) disable iff (!arst_n) dec_stb |=> !dec_stb)
		else begin
			$error("dec_stb held longer than one cycle");
			fail_count++;
		end
	drv_pulse: assert property (@(posedge clk) disable iff (!arst_n) drv_stb |=> !drv_stb)
		else begin
			$error("drv_stb held longer than one cycle");
			fail_count++;
		end

	// Outputs cleared while in reset, from the second reset edge on
	reset_clean: assert property (@(posedge clk) !arst_n ##1 !arst_n |->
		(cmp_event == '0 && out_xy == '0))
		else begin
			$error("outputs not zero during reset");
			fail_count++;
		end

endmodule

bind fdbk_core fdbk_core_props props_i (
	.clk(clk), .arst_n(arst_n), .sync(sync), .dec_stb(dec_stb), .drv_stb(drv_stb),
	.cmp_event(cmp_event), .out_xy(out_xy)
);

// ==== dv/fdbk_core_tb.sv ====
`timescale 1ns/1ps

module fdbk_core_tb;

	localparam int  cycle_limit = 6000;
	localparam real pi          = 3.14159265358979;

	logic                 clk;
	logic                 arst_n;
	logic                 sync;
	logic                 iq;
	fdbk_pkg::sample_t    in_xy;
	fdbk_pkg::fdbk_cfg_t  cfg;
	logic [1:0]           coarse_scale;
	fdbk_pkg::sample_t    out_xy;
	fdbk_pkg::cmp_event_t cmp_event;

	logic [2:0]  slot;
	logic        plant_on;
	int          fix_i;
	int          fix_q;
	int          step_d;
	logic        step_arm;
	logic [31:0] lfsr_state;
	int          cycles;

	clk_gen clk_gen_i (.clk(clk), .arst_n(arst_n));

	fdbk_core #(
		.cordic_stages(14),
		.use_ll_prop(1'b1)
	) fdbk_core_i (
		.clk(clk), .arst_n(arst_n), .sync(sync), .iq(iq), .in_xy(in_xy), .cfg(cfg),
		.coarse_scale(coarse_scale), .out_xy(out_xy), .cmp_event(cmp_event)
	);

	// Slot counter, I on even slots, sync on slot 0
	// Plant returns out_xy at half scale, which keeps I on I slots
	always @(posedge clk) begin : stim_blk
		logic [2:0] nslot;
		nslot = slot + 3'd1;
		slot <= nslot;
		sync <= (nslot == 3'd0);
		iq   <= !nslot[0];
		if (plant_on)
			in_xy <= out_xy >>> 1;
		else if (!nslot[0] && step_arm) begin
			in_xy    <= fdbk_pkg::sample_t'(fix_i + step_d);
			step_arm <= 1'b0;
		end else if (!nslot[0])
			in_xy <= fdbk_pkg::sample_t'(fix_i);
		else
			in_xy <= fdbk_pkg::sample_t'(fix_q);
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Run did not finish within %0d cycles", cycle_limit);
			$display("Result: FAILED");
			$fatal(1, "timeout");
		end
	end

	// Galois LFSR, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			r = {r[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
		end
		return r;
	endfunction

	task automatic abort_run();
		$display("Result: FAILED");
		$fatal(1, "check failed");
	endtask

	task automatic check_val(input string name, input int exp_v, input int act_v, input int tol);
		int diff;
		diff = (exp_v > act_v) ? exp_v - act_v : act_v - exp_v;
		assert (diff <= tol) else begin
			$display("[ERROR] %s expected %0d actual %0d", name, exp_v, act_v);
			abort_run();
		end
	endtask

	task automatic apply_cfg(input fdbk_pkg::fdbk_cfg_t c, input logic [1:0] cs,
		input logic plant, input int fi, input int fq);
		@(posedge clk);
		cfg          <= c;
		coarse_scale <= cs;
		plant_on     <= plant;
		fix_i        <= fi;
		fix_q        <= fq;
	endtask

	task automatic skip_frames(input int n);
		repeat (n * 8) @(posedge clk);
	endtask

	// out_xy carries the component of the slot before it
	task automatic read_out_pair(output int i_val, output int q_val);
		do @(negedge clk); while (!iq);
		@(negedge clk);
		i_val = out_xy;
		@(negedge clk);
		q_val = out_xy;
	endtask

	task automatic reset_values();
		@(negedge clk);
		while (!arst_n) begin
			assert (out_xy == '0 && cmp_event == '0) else begin
				$display("Outputs not zero during reset");
				abort_run();
			end
			@(negedge clk);
		end
		repeat (5) begin
			@(negedge clk);
			check_val("reset out_xy", 0, out_xy, 0);
			check_val("reset cmp_event", 0, cmp_event, 0);
		end
	endtask

	task automatic open_loop_drive();
		fdbk_pkg::fdbk_cfg_t c;
		logic [31:0]         r;
		int                  amp;
		int                  phi;
		int                  got_i;
		int                  got_q;
		real                 ang;
		amp = 20000 + rand_bits(15);
		r   = rand_bits(19);
		phi = $signed(r[18:0]);
		ang = phi * pi / 262144.0;
		c            = '0;
		c.mode       = fdbk_pkg::MODE_OPEN;
		c.lim_mag_hi = fdbk_pkg::mag_t'(amp);
		c.lim_mag_lo = fdbk_pkg::mag_t'(amp);
		c.ph_offset  = fdbk_pkg::phase_t'(phi);
		apply_cfg(c, 2'd0, 1'b0, 0, 0);
		skip_frames(20);
		// 1% of full scale
		repeat (4) begin
			read_out_pair(got_i, got_q);
			check_val("open_loop I", $rtoi(amp * $cos(ang)), got_i, 1311);
			check_val("open_loop Q", $rtoi(amp * $sin(ang)), got_q, 1311);
		end
	endtask

	task automatic poll_clip_flag(input string name, input logic want_hi);
		int n;
		n = 0;
		while (n < 160 && !(want_hi ? cmp_event.mag_hi : cmp_event.mag_lo)) begin
			@(negedge clk);
			n++;
		end
		assert (n < 160) else begin
			$display("%s: clip flag not set within 20 frames", name);
			abort_run();
		end
	endtask

	task automatic clip_flags();
		fdbk_pkg::fdbk_cfg_t c;
		c             = '0;
		c.mode        = fdbk_pkg::MODE_OPEN;
		c.set_mag     = 18'd100000;
		c.coeff_mag_i = 18'sd60000;
		c.coeff_mag_p = 18'sd30000;
		c.lim_mag_hi  = 18'd1000;
		apply_cfg(c, 2'd0, 1'b0, 0, 0);
		poll_clip_flag("clip_mag_hi", 1'b1);
		// Zero gains, output sits under the low limit
		c            = '0;
		c.mode       = fdbk_pkg::MODE_OPEN;
		c.lim_mag_hi = 18'd100000;
		c.lim_mag_lo = 18'd50000;
		apply_cfg(c, 2'd0, 1'b0, 0, 0);
		poll_clip_flag("clip_mag_lo", 1'b0);
	endtask

	task automatic closed_loop_settle();
		fdbk_pkg::fdbk_cfg_t c;
		int                  pi_v;
		int                  pq_v;
		int                  meas;
		c             = '0;
		c.mode        = fdbk_pkg::MODE_CLOSED;
		c.set_mag     = 18'd12000;
		c.coeff_mag_p = 18'sd20000;
		c.lim_mag_hi  = 18'd97000;
		c.lim_mag_lo  = 18'd95000;
		c.lim_ph_hi   = 19'sd100000;
		c.lim_ph_lo   = -19'sd100000;
		apply_cfg(c, 2'd0, 1'b1, 0, 0);
		skip_frames(150);
		repeat (4) begin
			do @(negedge clk); while (!iq);
			pi_v = in_xy;
			@(negedge clk);
			pq_v = in_xy;
			// Core sees four pairs summed then divided by 16
			meas = $rtoi($sqrt(real'(pi_v) * pi_v + real'(pq_v) * pq_v) / 4.0);
			check_val("closed_loop magnitude", 12000, meas, 240);
		end
	endtask

	task automatic ll_step_response(input int cs);
		fdbk_pkg::fdbk_cfg_t c;
		int                  gain;
		int                  d;
		int                  set_i;
		int                  set_q;
		int                  base;
		int                  exp_delta;
		gain  = 1024 + rand_bits(12);
		d     = 100 + rand_bits(10);
		if (rand_bits(1) == 1)
			d = -d;
		set_i = rand_bits(12) - 2048;
		set_q = rand_bits(12) - 2048;
		c            = '0;
		c.mode       = fdbk_pkg::MODE_OPEN;
		c.lim_mag_hi = 18'd20000;
		c.lim_mag_lo = 18'd20000;
		c.ll_set_i   = fdbk_pkg::sample_t'(set_i);
		c.ll_set_q   = fdbk_pkg::sample_t'(set_q);
		c.ll_gain    = 18'(gain);
		apply_cfg(c, 2'(cs), 1'b0, set_i, set_q);
		skip_frames(6);
		exp_delta = (-(gain * d)) >>> (2 * cs + 8);
		// Zero error baseline, then one stepped I sample
		do @(negedge clk); while (!iq);
		@(negedge clk);
		base     = out_xy;
		step_d   = d;
		step_arm = 1'b1;
		do @(negedge clk); while (!(iq && in_xy == fdbk_pkg::sample_t'(set_i + d)));
		@(negedge clk);
		check_val($sformatf("ll_prop scale %0d", cs), base + exp_delta, out_xy, 0);
	endtask

	initial begin
		slot         = '0;
		sync         = 1'b0;
		iq           = 1'b0;
		in_xy        = '0;
		cfg          = '0;
		coarse_scale = '0;
		plant_on     = 1'b0;
		fix_i        = 0;
		fix_q        = 0;
		step_d       = 0;
		step_arm     = 1'b0;
		lfsr_state   = 32'hfc08;
		cycles       = 0;
		reset_values();
		open_loop_drive();
		clip_flags();
		closed_loop_settle();
		for (int cs = 0; cs < 4; cs++)
			ll_step_response(cs);
		if (fdbk_core_i.props_i.fail_count == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== files.f ====
verilog/fdbk_pkg.sv
verilog/iq_decim.sv
verilog/cordic_mux.sv
verilog/mp_proc.sv
verilog/iq_interp.sv
verilog/ll_prop.sv
verilog/fdbk_core.sv
dv/clk_gen.sv
dv/fdbk_core_props.sv
dv/fdbk_core_tb.sv

// ==== verilog/cordic_mux.sv ====
`timescale 1ns/1ps

module cordic_mux #(
	parameter int cordic_stages = 14
) (
	input  logic              clk,
	input  logic              arst_n,
	input  fdbk_pkg::sample_t vec_i,
	input  fdbk_pkg::sample_t vec_q,
	input  logic              vec_stb,
	input  fdbk_pkg::mag_t    rot_mag,
	input  fdbk_pkg::phase_t  rot_ph,
	input  logic              rot_stb,
	output fdbk_pkg::mag_t    mag,
	output fdbk_pkg::phase_t  ph,
	output logic              mag_stb,
	output fdbk_pkg::sample_t out_i,
	output fdbk_pkg::sample_t out_q,
	output logic              out_stb
);

	// 1/K, K being the CORDIC gain, 2^18 is one
	localparam logic signed [18:0] gain_inv = 19'sd159188;

	fdbk_pkg::cordic_tok_t tok [0:cordic_stages];
	fdbk_pkg::cordic_tok_t tok_in;
	logic [cordic_stages:0] vld;
	logic                   hold_vld;
	fdbk_pkg::sample_t      hold_i;
	fdbk_pkg::sample_t      hold_q;
	fdbk_pkg::sample_t      src_i;
	fdbk_pkg::sample_t      src_q;
	logic signed [39:0]     px;
	logic signed [39:0]     py;

	// atan(2^-i), pi is 2^20
	function automatic logic signed [20:0] atan_lut(input int i);
		case (i)
			0: return 21'sd262144;
			1: return 21'sd154753;
			2: return 21'sd81767;
			3: return 21'sd41506;
			4: return 21'sd20834;
			5: return 21'sd10427;
			6: return 21'sd5215;
			7: return 21'sd2608;
			8: return 21'sd1304;
			9: return 21'sd652;
			10: return 21'sd326;
			11: return 21'sd163;
			12: return 21'sd81;
			13: return 21'sd41;
			14: return 21'sd20;
			15: return 21'sd10;
			default: return 21'sd0;
		endcase
	endfunction

	// Held vector goes in before a new one
	assign src_i = hold_vld ? hold_i : vec_i;
	assign src_q = hold_vld ? hold_q : vec_q;

	// Token entry, quadrant folded in here
	always_comb begin
		tok_in = '0;
		if (rot_stb) begin
			tok_in.op = fdbk_pkg::OP_ROTATE;
			tok_in.x  = {3'b000, rot_mag};
			tok_in.z  = {rot_ph, 2'b00};
			// Beyond +/- pi/2, start from -mag and turn by pi
			if (tok_in.z[20] != tok_in.z[19]) begin
				tok_in.x = -tok_in.x;
				tok_in.z = tok_in.z ^ 21'h100000;
			end
		end else begin
			tok_in.op = fdbk_pkg::OP_VECTOR;
			tok_in.x  = {{2{src_i[17]}}, src_i, 1'b0};
			tok_in.y  = {{2{src_q[17]}}, src_q, 1'b0};
			// Left half plane, mirror through the origin and start at pi
			if (tok_in.x[20]) begin
				tok_in.x = -tok_in.x;
				tok_in.y = -tok_in.y;
				tok_in.z = 21'h100000;
			end
		end
	end

	// Rotation wins a collision, the vector waits one cycle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			hold_vld <= 1'b0;
		else if (rot_stb && vec_stb)
			hold_vld <= 1'b1;
		else if (!rot_stb)
			hold_vld <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (rot_stb && vec_stb) begin
			hold_i <= vec_i;
			hold_q <= vec_q;
		end
		tok[0] <= tok_in;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			vld <= '0;
		else
			vld <= {vld[cordic_stages-1:0], rot_stb | hold_vld | vec_stb};
	end

	// Micro-rotations: vectoring drives y to zero, rotation drives z to zero
	for (genvar s = 0; s < cordic_stages; s++) begin : g_stage
		logic ccw;
		assign ccw = (tok[s].op == fdbk_pkg::OP_VECTOR) ? tok[s].y[20] : ~tok[s].z[20];
		always_ff @(posedge clk) begin
			tok[s+1].op <= tok[s].op;
			if (ccw) begin
				tok[s+1].x <= tok[s].x - (tok[s].y >>> s);
				tok[s+1].y <= tok[s].y + (tok[s].x >>> s);
				tok[s+1].z <= tok[s].z - atan_lut(s);
			end else begin
				tok[s+1].x <= tok[s].x + (tok[s].y >>> s);
				tok[s+1].y <= tok[s].y - (tok[s].x >>> s);
				tok[s+1].z <= tok[s].z + atan_lut(s);
			end
		end
	end

	// Gain compensation
	assign px = tok[cordic_stages].x * gain_inv;
	assign py = tok[cordic_stages].y * gain_inv;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mag_stb <= 1'b0;
			out_stb <= 1'b0;
		end else begin
			mag_stb <= vld[cordic_stages] && (tok[cordic_stages].op == fdbk_pkg::OP_VECTOR);
			out_stb <= vld[cordic_stages] && (tok[cordic_stages].op == fdbk_pkg::OP_ROTATE);
		end
	end

	// Vectoring x carries the input guard bit, hence 19
	always_ff @(posedge clk) begin
		mag   <= fdbk_pkg::mag_t'(px >>> 19);
		ph    <= tok[cordic_stages].z[20:2];
		out_i <= fdbk_pkg::sat_sample(px >>> 18);
		out_q <= fdbk_pkg::sat_sample(py >>> 18);
	end

endmodule

// ==== verilog/fdbk_core.sv ====
`timescale 1ns/1ps

module fdbk_core #(
	parameter int cordic_stages = 14,
	parameter bit use_ll_prop   = 1'b1
) (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 sync,
	input  logic                 iq,
	input  fdbk_pkg::sample_t    in_xy,
	input  fdbk_pkg::fdbk_cfg_t  cfg,
	input  logic [1:0]           coarse_scale,
	output fdbk_pkg::sample_t    out_xy,
	output fdbk_pkg::cmp_event_t cmp_event
);

	fdbk_pkg::acc_t    dec_i;
	fdbk_pkg::acc_t    dec_q;
	logic              dec_stb;
	fdbk_pkg::mag_t    mp_mag;
	fdbk_pkg::phase_t  mp_ph;
	logic              mp_stb;
	fdbk_pkg::mag_t    drv_mag;
	fdbk_pkg::phase_t  drv_ph;
	logic              drv_stb;
	fdbk_pkg::sample_t rot_i;
	fdbk_pkg::sample_t rot_q;
	logic              rot_stb;
	fdbk_pkg::sample_t drive_xy;

	// Decimate by four pairs
	iq_decim decim_i (
		.clk(clk), .arst_n(arst_n), .sync(sync), .iq(iq), .in_xy(in_xy),
		.dec_i(dec_i), .dec_q(dec_q), .dec_stb(dec_stb)
	);

	// Sum of four, scaled down by 16 for the CORDIC
	cordic_mux #(
		.cordic_stages(cordic_stages)
	) cordic_i (
		.clk(clk), .arst_n(arst_n),
		.vec_i(dec_i[21:4]), .vec_q(dec_q[21:4]), .vec_stb(dec_stb),
		.rot_mag(drv_mag), .rot_ph(drv_ph), .rot_stb(drv_stb),
		.mag(mp_mag), .ph(mp_ph), .mag_stb(mp_stb),
		.out_i(rot_i), .out_q(rot_q), .out_stb(rot_stb)
	);

	// Slow PI loop in polar form
	mp_proc mp_i (
		.clk(clk), .arst_n(arst_n), .cfg(cfg),
		.in_mag(mp_mag), .in_ph(mp_ph), .in_stb(mp_stb),
		.drv_mag(drv_mag), .drv_ph(drv_ph), .drv_stb(drv_stb),
		.cmp_event(cmp_event)
	);

	// Back to full rate
	iq_interp interp_i (
		.clk(clk), .arst_n(arst_n), .sync(sync), .iq(iq),
		.in_i(rot_i), .in_q(rot_q), .in_stb(rot_stb), .drive_xy(drive_xy)
	);

	// Fast path, one cycle from in_xy
	ll_prop #(
		.use_ll_prop(use_ll_prop)
	) prop_i (
		.clk(clk), .arst_n(arst_n), .iq(iq), .in_xy(in_xy), .drive_xy(drive_xy),
		.cfg(cfg), .coarse_scale(coarse_scale), .out_xy(out_xy)
	);

endmodule

// ==== verilog/fdbk_pkg.sv ====
package fdbk_pkg;

	// Data words
	typedef logic signed [17:0] sample_t;
	typedef logic signed [21:0] acc_t;
	typedef logic [17:0] mag_t;
	// Full scale is +/- pi
	typedef logic signed [18:0] phase_t;

	// Conversion carried by a CORDIC token
	typedef enum logic {
		OP_VECTOR = 1'b0,
		OP_ROTATE = 1'b1
	} cordic_op_t;

	// Open loop drives the phase from ph_offset
	typedef enum logic {
		MODE_OPEN   = 1'b0,
		MODE_CLOSED = 1'b1
	} loop_mode_t;

	typedef struct packed {
		mag_t               set_mag;
		phase_t             set_ph;
		logic signed [17:0] coeff_mag_i;
		logic signed [17:0] coeff_ph_i;
		logic signed [17:0] coeff_mag_p;
		logic signed [17:0] coeff_ph_p;
		mag_t               lim_mag_hi;
		mag_t               lim_mag_lo;
		phase_t             lim_ph_hi;
		phase_t             lim_ph_lo;
		phase_t             ph_offset;
		loop_mode_t         mode;
		sample_t            ll_set_i;
		sample_t            ll_set_q;
		logic signed [17:0] ll_gain;
	} fdbk_cfg_t;

	// Two guard bits on x and y, z scaled so that pi is 2^20
	typedef struct packed {
		cordic_op_t         op;
		logic signed [20:0] x;
		logic signed [20:0] y;
		logic signed [20:0] z;
	} cordic_tok_t;

	typedef struct packed {
		logic mag_hi;
		logic mag_lo;
		logic ph_hi;
		logic ph_lo;
	} cmp_event_t;

	// Clamp a wide signed value into one sample
	function automatic sample_t sat_sample(input logic signed [39:0] v);
		if (v > 40'sd131071)
			return 18'sd131071;
		else if (v < -40'sd131072)
			return -18'sd131072;
		else
			return v[17:0];
	endfunction

endpackage

// ==== verilog/iq_decim.sv ====
`timescale 1ns/1ps

module iq_decim (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              sync,
	input  logic              iq,
	input  fdbk_pkg::sample_t in_xy,
	output fdbk_pkg::acc_t    dec_i,
	output fdbk_pkg::acc_t    dec_q,
	output logic              dec_stb
);

	logic [2:0]     slot;
	logic           last;
	fdbk_pkg::acc_t acc_i;
	fdbk_pkg::acc_t acc_q;
	fdbk_pkg::acc_t sum_i;
	fdbk_pkg::acc_t sum_q;

	// Sums including the current sample
	// sync drops the previous frame
	always_comb begin
		sum_i = sync ? '0 : acc_i;
		sum_q = sync ? '0 : acc_q;
		if (iq)
			sum_i = sum_i + in_xy;
		else
			sum_q = sum_q + in_xy;
	end

	// Slot 7 holds the last Q sample of the frame
	assign last = (slot == 3'd7) && !sync;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			slot    <= '0;
			acc_i   <= '0;
			acc_q   <= '0;
			dec_i   <= '0;
			dec_q   <= '0;
			dec_stb <= 1'b0;
		end else begin
			slot    <= sync ? 3'd1 : slot + 3'd1;
			acc_i   <= sum_i;
			acc_q   <= sum_q;
			dec_stb <= last;
			if (last) begin
				dec_i <= sum_i;
				dec_q <= sum_q;
			end
		end
	end

endmodule

// ==== verilog/iq_interp.sv ====
`timescale 1ns/1ps

module iq_interp (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              sync,
	input  logic              iq,
	input  fdbk_pkg::sample_t in_i,
	input  fdbk_pkg::sample_t in_q,
	input  logic              in_stb,
	output fdbk_pkg::sample_t drive_xy
);

	fdbk_pkg::sample_t  tgt_i;
	fdbk_pkg::sample_t  tgt_q;
	fdbk_pkg::sample_t  last_i;
	fdbk_pkg::sample_t  last_q;
	fdbk_pkg::sample_t  cur_i;
	fdbk_pkg::sample_t  cur_q;
	fdbk_pkg::sample_t  step_i;
	fdbk_pkg::sample_t  step_q;
	fdbk_pkg::sample_t  nxt_i;
	fdbk_pkg::sample_t  nxt_q;
	logic signed [18:0] d_i;
	logic signed [18:0] d_q;
	logic               pend;
	logic [1:0]         pair;

	// Quarter of the jump to the pending target
	assign d_i = (tgt_i - last_i) >>> 2;
	assign d_q = (tgt_q - last_q) >>> 2;

	// Pair value, the fourth pair lands exactly on the target
	always_comb begin
		if (sync) begin
			nxt_i = pend ? last_i + d_i[17:0] : last_i;
			nxt_q = pend ? last_q + d_q[17:0] : last_q;
		end else if (pair == 2'd3) begin
			nxt_i = last_i;
			nxt_q = last_q;
		end else begin
			nxt_i = cur_i + step_i;
			nxt_q = cur_q + step_q;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			{tgt_i, tgt_q, last_i, last_q} <= '0;
			{cur_i, cur_q, step_i, step_q} <= '0;
			pend     <= 1'b0;
			pair     <= '0;
			drive_xy <= '0;
		end else begin
			if (sync && pend) begin
				last_i <= tgt_i;
				last_q <= tgt_q;
				step_i <= d_i[17:0];
				step_q <= d_q[17:0];
				pend   <= 1'b0;
			end else if (sync) begin
				step_i <= '0;
				step_q <= '0;
			end
			// A new target waits for the next frame
			if (in_stb) begin
				tgt_i <= in_i;
				tgt_q <= in_q;
				pend  <= 1'b1;
			end
			// Pair advances on I slots, output runs one slot ahead of iq
			if (iq) begin
				pair     <= sync ? 2'd1 : pair + 2'd1;
				cur_i    <= nxt_i;
				cur_q    <= nxt_q;
				drive_xy <= nxt_q;
			end else begin
				drive_xy <= cur_i;
			end
		end
	end

endmodule

// ==== verilog/ll_prop.sv ====
`timescale 1ns/1ps

module ll_prop #(
	parameter bit use_ll_prop = 1'b1
) (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                iq,
	input  fdbk_pkg::sample_t   in_xy,
	input  fdbk_pkg::sample_t   drive_xy,
	input  fdbk_pkg::fdbk_cfg_t cfg,
	input  logic [1:0]          coarse_scale,
	output fdbk_pkg::sample_t   out_xy
);

	if (use_ll_prop) begin : g_prop
		logic signed [18:0] err;
		logic signed [36:0] prod;
		logic signed [36:0] corr;
		logic signed [39:0] sum;
		logic [3:0]         shift;

		// Shift of 8, 10, 12 or 14
		assign shift = {1'b0, coarse_scale, 1'b0} + 4'd8;

		always_comb begin
			// Setpoint of the component on the wire now
			err  = (iq ? cfg.ll_set_i : cfg.ll_set_q) - in_xy;
			prod = err * cfg.ll_gain;
			corr = prod >>> shift;
			sum  = corr + drive_xy;
		end

		always_ff @(posedge clk or negedge arst_n) begin
			if (!arst_n)
				out_xy <= '0;
			else
				out_xy <= fdbk_pkg::sat_sample(sum);
		end
	end else begin : g_plain
		// Same single register so latency does not move
		always_ff @(posedge clk or negedge arst_n) begin
			if (!arst_n)
				out_xy <= '0;
			else
				out_xy <= drive_xy;
		end
	end

endmodule

// ==== verilog/mp_proc.sv ====
`timescale 1ns/1ps

module mp_proc (
	input  logic                 clk,
	input  logic                 arst_n,
	input  fdbk_pkg::fdbk_cfg_t  cfg,
	input  fdbk_pkg::mag_t       in_mag,
	input  fdbk_pkg::phase_t     in_ph,
	input  logic                 in_stb,
	output fdbk_pkg::mag_t       drv_mag,
	output fdbk_pkg::phase_t     drv_ph,
	output logic                 drv_stb,
	output fdbk_pkg::cmp_event_t cmp_event
);

	logic signed [18:0] err_mag;
	logic signed [18:0] err_ph;
	logic               err_stb;
	logic signed [43:0] int_mag;
	logic signed [43:0] int_ph;
	logic signed [43:0] int_mag_nx;
	logic signed [43:0] int_ph_nx;
	logic signed [43:0] raw_mag;
	logic signed [43:0] raw_ph;
	logic signed [43:0] lim_mag_hi;
	logic signed [43:0] lim_mag_lo;
	logic signed [43:0] lim_ph_hi;
	logic signed [43:0] lim_ph_lo;
	logic               hold_mag;
	logic               hold_ph;
	logic               open_loop;

	assign open_loop = (cfg.mode == fdbk_pkg::MODE_OPEN);

	// Stage 1: errors, phase wraps at +/- pi
	always_ff @(posedge clk) begin
		if (in_stb) begin
			err_mag <= $signed({1'b0, cfg.set_mag}) - $signed({1'b0, in_mag});
			err_ph  <= cfg.set_ph - in_ph;
		end
	end

	// Limits widened, magnitude ones are unsigned
	assign lim_mag_hi = $signed({26'd0, cfg.lim_mag_hi});
	assign lim_mag_lo = $signed({26'd0, cfg.lim_mag_lo});
	assign lim_ph_hi  = 44'(cfg.lim_ph_hi);
	assign lim_ph_lo  = 44'(cfg.lim_ph_lo);

	// Anti-windup: no integration further into a clipped limit
	assign hold_mag = (cmp_event.mag_hi && !err_mag[18] && err_mag != 0) ||
		(cmp_event.mag_lo && err_mag[18]);
	assign hold_ph = open_loop || (cmp_event.ph_hi && !err_ph[18] && err_ph != 0) ||
		(cmp_event.ph_lo && err_ph[18]);

	// Stage 2: integral plus proportional
	// Integrator carries 8 more fraction bits than the P term
	always_comb begin
		int_mag_nx = hold_mag ? int_mag : int_mag + err_mag * cfg.coeff_mag_i;
		int_ph_nx  = hold_ph ? int_ph : int_ph + err_ph * cfg.coeff_ph_i;
		raw_mag    = (int_mag_nx + ((err_mag * cfg.coeff_mag_p) <<< 8)) >>> 25;
		raw_ph     = (int_ph_nx + ((err_ph * cfg.coeff_ph_p) <<< 8)) >>> 25;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			err_stb   <= 1'b0;
			drv_stb   <= 1'b0;
			int_mag   <= '0;
			int_ph    <= '0;
			drv_mag   <= '0;
			drv_ph    <= '0;
			cmp_event <= '0;
		end else begin
			err_stb <= in_stb;
			drv_stb <= err_stb;
			if (err_stb) begin
				int_mag <= int_mag_nx;
				int_ph  <= int_ph_nx;
				// High limit checked first
				cmp_event.mag_hi <= raw_mag > lim_mag_hi;
				cmp_event.mag_lo <= raw_mag <= lim_mag_hi && raw_mag < lim_mag_lo;
				if (raw_mag > lim_mag_hi)
					drv_mag <= cfg.lim_mag_hi;
				else if (raw_mag < lim_mag_lo)
					drv_mag <= cfg.lim_mag_lo;
				else
					drv_mag <= fdbk_pkg::mag_t'(raw_mag);
				// Open loop: phase straight from ph_offset, no phase clip
				cmp_event.ph_hi <= !open_loop && raw_ph > lim_ph_hi;
				cmp_event.ph_lo <= !open_loop && raw_ph <= lim_ph_hi && raw_ph < lim_ph_lo;
				if (open_loop)
					drv_ph <= cfg.ph_offset;
				else if (raw_ph > lim_ph_hi)
					drv_ph <= cfg.lim_ph_hi;
				else if (raw_ph < lim_ph_lo)
					drv_ph <= cfg.lim_ph_lo;
				else
					drv_ph <= fdbk_pkg::phase_t'(raw_ph);
			end
		end
	end

endmodule
